/* gpio_pkg.sv */
// GPIO padframe shared definitions

package gpio_pkg;

    // Bits in one pad configuration word
    localparam int PAD_CTRL_BITS = 13;

    // Configuration word, first member is the MSB
    typedef struct packed {
        logic [2:0] dm;          // Drive mode, bits 12:10
        logic       vtrip_sel;   // Input trip point, bit 9
        logic       slow_sel;    // Slew control, bit 8
        logic       ana_pol;     // Analog polarity, bit 7
        logic       ana_sel;     // Analog bus select, bit 6
        logic       ana_en;      // Analog enable, bit 5
        logic       ib_mode_sel; // Input buffer mode, bit 4
        logic       inenb;       // Input disable, bit 3
        logic       holdover;    // Hold latched state, bit 2
        logic       outenb;      // Output disable, bit 1
        logic       mgmt_ena;    // Management owns pad, bit 0
    } pad_cfg_t;

    // Word after reset, management input only
    localparam pad_cfg_t PAD_CFG_RESET = '{
        dm:          3'b001,     // Input only drive mode
        vtrip_sel:   1'b0,       // CMOS trip point
        slow_sel:    1'b0,       // Fast slew
        ana_pol:     1'b0,
        ana_sel:     1'b0,
        ana_en:      1'b0,       // Digital path
        ib_mode_sel: 1'b0,
        inenb:       1'b0,       // Input buffer on
        holdover:    1'b0,
        outenb:      1'b1,       // Output off
        mgmt_ena:    1'b1        // Management side owns the pad
    };

    // Pad-facing controls of one pad
    typedef struct packed {
        logic       holdover;
        logic       slow_sel;
        logic       vtrip_sel;
        logic       inenb;
        logic       ib_mode_sel;
        logic       ana_en;
        logic       ana_sel;
        logic       ana_pol;
        logic [2:0] dm;
        logic       outenb;      // Muxed from owner side
        logic       out;         // Muxed from owner side
    } pad_pins_t;

    // Serial configuration master sequencer
    typedef enum logic [1:0] {
        CFG_IDLE  = 2'd0,        // Waiting for start
        CFG_SHIFT = 2'd1,        // Streaming words into the chain
        CFG_LOAD  = 2'd2         // One cycle load strobe
    } cfg_state_e;

endpackage

/* gpio_control_block.sv */
// GPIO pad control block

`timescale 1ns/1ps

module gpio_control_block #(
    parameter gpio_pkg::pad_cfg_t CFG_INIT = gpio_pkg::PAD_CFG_RESET  // Word after reset
) (
    input  logic                load_data,       // System clock
    input  logic                int_reset,       // Async reset, active high

    // Configuration chain
    input  logic                cfg_shift,       // Shift one bit this cycle
    input  logic                cfg_load,        // Latch stage into config
    input  logic                serial_data_in,  // From previous block or master
    output logic                serial_data_out, // To next block or master

    // Management side
    input  logic                mgmt_gpio_out,   // Management drive value
    input  logic                mgmt_gpio_oeb,   // Management output disable
    output logic                mgmt_gpio_in,    // Pad input to management

    // User side
    input  logic                user_gpio_out,   // User drive value
    input  logic                user_gpio_oeb,   // User output disable
    output logic                user_gpio_in,    // Pad input to user

    // Pad side
    input  logic                pad_gpio_in,     // Value seen at the pad
    output gpio_pkg::pad_pins_t pad_pins         // Controls to the pad cell
);

    logic [gpio_pkg::PAD_CTRL_BITS-1:0] shift_q; // Serial stage
    gpio_pkg::pad_cfg_t                 cfg_q;   // Latched configuration

    // Serial stage, MSB leaves first
    always_ff @(posedge load_data or posedge int_reset) begin
        if (int_reset) begin
            shift_q <= '0;                                    // Empty chain
        end else if (cfg_shift) begin
            shift_q <= {shift_q[gpio_pkg::PAD_CTRL_BITS-2:0], serial_data_in};
        end
    end

    assign serial_data_out = shift_q[gpio_pkg::PAD_CTRL_BITS-1]; // Chain onward

    // Configuration latch
    always_ff @(posedge load_data or posedge int_reset) begin
        if (int_reset) begin
            cfg_q <= CFG_INIT;                                // Safe startup word
        end else if (cfg_load) begin
            cfg_q <= gpio_pkg::pad_cfg_t'(shift_q);           // Take the whole word
        end
    end

    // Static pad controls straight from the latch
    assign pad_pins.holdover    = cfg_q.holdover;
    assign pad_pins.slow_sel    = cfg_q.slow_sel;
    assign pad_pins.vtrip_sel   = cfg_q.vtrip_sel;
    assign pad_pins.inenb       = cfg_q.inenb;
    assign pad_pins.ib_mode_sel = cfg_q.ib_mode_sel;
    assign pad_pins.ana_en      = cfg_q.ana_en;
    assign pad_pins.ana_sel     = cfg_q.ana_sel;
    assign pad_pins.ana_pol     = cfg_q.ana_pol;
    assign pad_pins.dm          = cfg_q.dm;

    // Owner selects the output path
    assign pad_pins.out    = cfg_q.mgmt_ena ? mgmt_gpio_out : user_gpio_out;
    assign pad_pins.outenb = cfg_q.mgmt_ena ? mgmt_gpio_oeb : user_gpio_oeb;

    // Input goes to the owner only, other side reads zero
    assign mgmt_gpio_in = cfg_q.mgmt_ena ? pad_gpio_in : 1'b0;
    assign user_gpio_in = cfg_q.mgmt_ena ? 1'b0 : pad_gpio_in;

endmodule

/* serial_cfg_master.sv */
// Serial configuration master

`timescale 1ns/1ps

module serial_cfg_master #(
    parameter int N_PADS = 4                                     // Pads on the chain
) (
    input  logic                                            load_data,  // System clock
    input  logic                                            int_reset,  // Async reset

    // Host side
    input  logic                                            cfg_wr,     // Write strobe
    input  logic                                            cfg_start,  // Start strobe
    input  logic [$clog2(N_PADS > 1 ? N_PADS : 2)-1:0]      cfg_addr,   // Write slot
    input  gpio_pkg::pad_cfg_t                              cfg_data,   // Write word
    input  logic [$clog2(N_PADS > 1 ? N_PADS : 2)-1:0]      rd_addr,    // Readback slot
    output gpio_pkg::pad_cfg_t                              rd_data,    // Readback word
    output logic                                            busy,       // Transfer running
    output logic                                            done,       // Transfer finished

    // Chain side
    output logic                                            cfg_shift,  // Shift strobe
    output logic                                            cfg_load,   // Load strobe
    output logic                                            serial_data_out, // Into pad 0
    input  logic                                            chain_return     // From last pad
);

    localparam int ADDR_W = $clog2(N_PADS > 1 ? N_PADS : 2);    // Slot index width
    localparam int BIT_W  = $clog2(gpio_pkg::PAD_CTRL_BITS);     // Bit index width
    localparam logic [ADDR_W-1:0] LAST_PAD = ADDR_W'(N_PADS - 1);
    localparam logic [BIT_W-1:0]  TOP_BIT  = BIT_W'(gpio_pkg::PAD_CTRL_BITS - 1);

    logic [gpio_pkg::PAD_CTRL_BITS-1:0] cfg_mem [N_PADS];        // Words to send
    logic [gpio_pkg::PAD_CTRL_BITS-1:0] rd_mem  [N_PADS];        // Words returned
    gpio_pkg::cfg_state_e               state_q;                 // Sequencer state
    logic [ADDR_W-1:0]                  pad_idx;                 // Pad being sent
    logic [BIT_W-1:0]                   bit_idx;                 // Bit being sent
    logic                               done_q;

    // Strobes decode straight from the state
    assign busy      = (state_q != gpio_pkg::CFG_IDLE);
    assign cfg_shift = (state_q == gpio_pkg::CFG_SHIFT);
    assign cfg_load  = (state_q == gpio_pkg::CFG_LOAD);
    assign done      = done_q;

    // Current chain bit, quiet when not shifting
    assign serial_data_out = cfg_shift ? cfg_mem[pad_idx][bit_idx] : 1'b0;

    // Host word store, locked during a transfer
    always_ff @(posedge load_data) begin
        if (cfg_wr && !busy && (int'(cfg_addr) < N_PADS)) begin
            cfg_mem[cfg_addr] <= cfg_data;
        end
    end

    // Sequencer, last pad first and MSB first
    always_ff @(posedge load_data or posedge int_reset) begin
        if (int_reset) begin
            state_q <= gpio_pkg::CFG_IDLE;
            pad_idx <= '0;
            bit_idx <= '0;
            done_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;                                     // Single cycle pulse
            case (state_q)
                gpio_pkg::CFG_IDLE: begin
                    if (cfg_start) begin
                        state_q <= gpio_pkg::CFG_SHIFT;
                        pad_idx <= LAST_PAD;                     // Far end goes first
                        bit_idx <= TOP_BIT;
                    end
                end
                gpio_pkg::CFG_SHIFT: begin
                    if (bit_idx == '0) begin
                        if (pad_idx == '0) begin
                            state_q <= gpio_pkg::CFG_LOAD;       // All bits placed
                        end else begin
                            pad_idx <= pad_idx - 1'b1;           // Next word
                            bit_idx <= TOP_BIT;
                        end
                    end else begin
                        bit_idx <= bit_idx - 1'b1;
                    end
                end
                gpio_pkg::CFG_LOAD: begin
                    state_q <= gpio_pkg::CFG_IDLE;
                    done_q  <= 1'b1;                             // Flag the host
                end
                default: begin
                    state_q <= gpio_pkg::CFG_IDLE;               // Recover from bad code
                end
            endcase
        end
    end

    // Chain end carries the old contents in the same order
    always_ff @(posedge load_data or posedge int_reset) begin
        if (int_reset) begin
            for (int i = 0; i < N_PADS; i++) begin
                rd_mem[i] <= '0;
            end
        end else if (cfg_shift) begin
            rd_mem[pad_idx][bit_idx] <= chain_return;            // Same slot as outgoing bit
        end
    end

    // Readback view, zero for slots past the last pad
    assign rd_data = (int'(rd_addr) < N_PADS) ? gpio_pkg::pad_cfg_t'(rd_mem[rd_addr])
                                               : gpio_pkg::pad_cfg_t'('0);

endmodule

/* gpio_padframe_top.sv */
// GPIO padframe configuration top

`timescale 1ns/1ps

module gpio_padframe_top #(
    parameter int N_PADS = 4                                     // Pads, 1 to 16
) (
    input  logic                                       load_data,   // System clock
    input  logic                                       int_reset,   // Async reset

    // Host side
    input  logic                                       cfg_wr,
    input  logic                                       cfg_start,
    input  logic [$clog2(N_PADS > 1 ? N_PADS : 2)-1:0] cfg_addr,
    input  gpio_pkg::pad_cfg_t                         cfg_data,
    input  logic [$clog2(N_PADS > 1 ? N_PADS : 2)-1:0] rd_addr,
    output gpio_pkg::pad_cfg_t                         rd_data,
    output logic                                       busy,
    output logic                                       done,

    // Per-pad core signals, bit i is pad i
    input  logic [N_PADS-1:0]                          mgmt_gpio_out,
    input  logic [N_PADS-1:0]                          mgmt_gpio_oeb,
    output logic [N_PADS-1:0]                          mgmt_gpio_in,
    input  logic [N_PADS-1:0]                          user_gpio_out,
    input  logic [N_PADS-1:0]                          user_gpio_oeb,
    output logic [N_PADS-1:0]                          user_gpio_in,

    // Pad side
    input  logic [N_PADS-1:0]                          pad_gpio_in,
    output gpio_pkg::pad_pins_t                        pad_pins [N_PADS]
);

    logic [N_PADS:0] chain;                                      // Serial links, 0 from master
    logic            cfg_shift;                                  // Shared shift strobe
    logic            cfg_load;                                   // Shared load strobe

    serial_cfg_master #(
        .N_PADS (N_PADS)
    ) i_serial_cfg_master (
        .load_data       (load_data),
        .int_reset       (int_reset),
        .cfg_wr          (cfg_wr),
        .cfg_start       (cfg_start),
        .cfg_addr        (cfg_addr),
        .cfg_data        (cfg_data),
        .rd_addr         (rd_addr),
        .rd_data         (rd_data),
        .busy            (busy),
        .done            (done),
        .cfg_shift       (cfg_shift),
        .cfg_load        (cfg_load),
        .serial_data_out (chain[0]),
        .chain_return    (chain[N_PADS])                         // Loop closes here
    );

    // One control block per pad, daisy chained
    for (genvar i = 0; i < N_PADS; i++) begin : g_pad
        gpio_control_block #(
            .CFG_INIT (gpio_pkg::PAD_CFG_RESET)
        ) i_gpio_control_block (
            .load_data       (load_data),
            .int_reset       (int_reset),
            .cfg_shift       (cfg_shift),
            .cfg_load        (cfg_load),
            .serial_data_in  (chain[i]),
            .serial_data_out (chain[i+1]),
            .mgmt_gpio_out   (mgmt_gpio_out[i]),
            .mgmt_gpio_oeb   (mgmt_gpio_oeb[i]),
            .mgmt_gpio_in    (mgmt_gpio_in[i]),
            .user_gpio_out   (user_gpio_out[i]),
            .user_gpio_oeb   (user_gpio_oeb[i]),
            .user_gpio_in    (user_gpio_in[i]),
            .pad_gpio_in     (pad_gpio_in[i]),
            .pad_pins        (pad_pins[i])
        );
    end

endmodule

/* gpio_padframe_asserts.sv */
// Control block assertions

`timescale 1ns/1ps

module gpio_padframe_asserts (
    input logic               load_data,
    input logic               int_reset,
    input logic               cfg_shift,
    input logic               cfg_load,
    input gpio_pkg::pad_cfg_t cfg_q,
    input logic               mgmt_gpio_in,
    input logic               user_gpio_in
);

    // Load and shift strobes are exclusive
    load_not_shift: assert property (@(posedge load_data) disable iff (int_reset)
        !(cfg_load && cfg_shift))
        else $error("cfg_load and cfg_shift high together");

    // Latch moves only on the edge that saw cfg_load
    cfg_only_on_load: assert property (@(posedge load_data) disable iff (int_reset)
        $changed(cfg_q) |-> $past(cfg_load))
        else $error("configuration changed without cfg_load");

    // Pad input reaches one owner at most
    one_input_owner: assert property (@(posedge load_data) disable iff (int_reset)
        !(mgmt_gpio_in && user_gpio_in))
        else $error("mgmt_gpio_in and user_gpio_in both high");

endmodule

bind gpio_control_block gpio_padframe_asserts i_gpio_padframe_asserts (
    .load_data    (load_data),
    .int_reset    (int_reset),
    .cfg_shift    (cfg_shift),
    .cfg_load     (cfg_load),
    .cfg_q        (cfg_q),
    .mgmt_gpio_in (mgmt_gpio_in),
    .user_gpio_in (user_gpio_in)
);

/* tb_gpio_padframe.sv */
// GPIO padframe testbench

`timescale 1ns/1ps

module tb_gpio_padframe;

    localparam int N_PADS       = 4;
    localparam int ADDR_W       = $clog2(N_PADS);
    localparam int LATENCY      = N_PADS * gpio_pkg::PAD_CTRL_BITS + 2; // Start to done
    localparam int DONE_TIMEOUT = 200;                                   // Cycles per wait
    localparam int SEED         = 19332;

    logic                load_data;
    logic                int_reset;
    logic                cfg_wr;
    logic                cfg_start;
    logic [ADDR_W-1:0]   cfg_addr;
    gpio_pkg::pad_cfg_t  cfg_data;
    logic [ADDR_W-1:0]   rd_addr;
    gpio_pkg::pad_cfg_t  rd_data;
    logic                busy;
    logic                done;
    logic [N_PADS-1:0]   mgmt_gpio_out;
    logic [N_PADS-1:0]   mgmt_gpio_oeb;
    logic [N_PADS-1:0]   mgmt_gpio_in;
    logic [N_PADS-1:0]   user_gpio_out;
    logic [N_PADS-1:0]   user_gpio_oeb;
    logic [N_PADS-1:0]   user_gpio_in;
    logic [N_PADS-1:0]   pad_gpio_in;
    gpio_pkg::pad_pins_t pad_pins [N_PADS];

    gpio_padframe_top #(
        .N_PADS (N_PADS)
    ) i_gpio_padframe_top (
        .load_data     (load_data),
        .int_reset     (int_reset),
        .cfg_wr        (cfg_wr),
        .cfg_start     (cfg_start),
        .cfg_addr      (cfg_addr),
        .cfg_data      (cfg_data),
        .rd_addr       (rd_addr),
        .rd_data       (rd_data),
        .busy          (busy),
        .done          (done),
        .mgmt_gpio_out (mgmt_gpio_out),
        .mgmt_gpio_oeb (mgmt_gpio_oeb),
        .mgmt_gpio_in  (mgmt_gpio_in),
        .user_gpio_out (user_gpio_out),
        .user_gpio_oeb (user_gpio_oeb),
        .user_gpio_in  (user_gpio_in),
        .pad_gpio_in   (pad_gpio_in),
        .pad_pins      (pad_pins)
    );

    always #10 load_data = ~load_data;                  // 20 ns period

    task automatic abort_run();
        $display("Testbench failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_cfg(input string name, input gpio_pkg::pad_cfg_t got,
                             input gpio_pkg::pad_cfg_t exp);
        if (got !== exp) begin
            $display("ERROR %s got 0x%h expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_pins(input string name, input gpio_pkg::pad_pins_t got,
                              input gpio_pkg::pad_pins_t exp);
        if (got !== exp) begin
            $display("ERROR %s got 0x%h expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR %s got 0x%h expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    // Pad controls a word should produce, owner side picks out and outenb
    function automatic gpio_pkg::pad_pins_t expected_pins(input gpio_pkg::pad_cfg_t w,
            input logic m_out, input logic m_oeb, input logic u_out, input logic u_oeb);
        gpio_pkg::pad_pins_t p;
        p.holdover    = w.holdover;
        p.slow_sel    = w.slow_sel;
        p.vtrip_sel   = w.vtrip_sel;
        p.inenb       = w.inenb;
        p.ib_mode_sel = w.ib_mode_sel;
        p.ana_en      = w.ana_en;
        p.ana_sel     = w.ana_sel;
        p.ana_pol     = w.ana_pol;
        p.dm          = w.dm;
        p.out         = w.mgmt_ena ? m_out : u_out;
        p.outenb      = w.mgmt_ena ? m_oeb : u_oeb;
        return p;
    endfunction

    // New random core and pad values on every pad
    task automatic drive_random();
        logic [31:0] rnd;
        rnd           = $urandom();
        mgmt_gpio_out = rnd[0*N_PADS +: N_PADS];
        mgmt_gpio_oeb = rnd[1*N_PADS +: N_PADS];
        user_gpio_out = rnd[2*N_PADS +: N_PADS];
        user_gpio_oeb = rnd[3*N_PADS +: N_PADS];
        pad_gpio_in   = rnd[4*N_PADS +: N_PADS];
    endtask

    task automatic write_word(input logic [ADDR_W-1:0] pad, input gpio_pkg::pad_cfg_t word);
        @(negedge load_data);
        cfg_wr   = 1'b1;
        cfg_addr = pad;
        cfg_data = word;
        @(negedge load_data);
        cfg_wr   = 1'b0;
    endtask

    // Start strobe then cycle by cycle busy and done checks until done
    task automatic run_transfer(input bit busy_write, input logic [ADDR_W-1:0] pad,
                                input gpio_pkg::pad_cfg_t word);
        int cycles;
        bit seen;
        cycles = 0;
        seen   = 1'b0;
        @(negedge load_data);
        cfg_start = 1'b1;
        while (!seen && cycles < DONE_TIMEOUT) begin
            @(negedge load_data);
            cfg_start = 1'b0;
            cycles++;
            if (busy_write && cycles == 10) begin         // Mid transfer write attempt
                cfg_wr   = 1'b1;
                cfg_addr = pad;
                cfg_data = word;
            end else begin
                cfg_wr = 1'b0;
            end
            check_bit("done", done, cycles == LATENCY);
            check_bit("busy", busy, cycles < LATENCY);   // Low once done is up
            seen = done;
        end
        if (!seen) begin
            $display("Timeout while waiting for done after %0d cycles", cycles);
            abort_run();
        end
    endtask

    task automatic check_readback(input logic [ADDR_W-1:0] pad, input gpio_pkg::pad_cfg_t word);
        @(negedge load_data);
        rd_addr = pad;
        #2;                                               // Combinational read settles
        check_cfg($sformatf("rd_data[%0d]", pad), rd_data, word);
    endtask

    // Static fields plus owner routing under a few random drive sets
    task automatic check_pad(input int pad, input gpio_pkg::pad_cfg_t word);
        gpio_pkg::pad_pins_t exp;
        for (int r = 0; r < 4; r++) begin
            @(negedge load_data);
            drive_random();
            #2;
            exp = expected_pins(word, mgmt_gpio_out[pad], mgmt_gpio_oeb[pad],
                                user_gpio_out[pad], user_gpio_oeb[pad]);
            check_pins($sformatf("pad_pins[%0d]", pad), pad_pins[pad], exp);
            check_bit($sformatf("mgmt_gpio_in[%0d]", pad), mgmt_gpio_in[pad],
                      word.mgmt_ena ? pad_gpio_in[pad] : 1'b0);
            check_bit($sformatf("user_gpio_in[%0d]", pad), user_gpio_in[pad],
                      word.mgmt_ena ? 1'b0 : pad_gpio_in[pad]);
        end
    endtask

    initial begin
        int          fd;
        string       line;
        logic [7:0]  cmd;
        logic [31:0] pad_val;
        logic [31:0] word_val;
        gpio_pkg::pad_cfg_t word;
        void'($urandom(SEED));
        load_data     = 1'b0;
        int_reset     = 1'b1;
        cfg_wr        = 1'b0;
        cfg_start     = 1'b0;
        cfg_addr      = '0;
        cfg_data      = '0;
        rd_addr       = '0;
        mgmt_gpio_out = '0;
        mgmt_gpio_oeb = '0;
        user_gpio_out = '0;
        user_gpio_oeb = '0;
        pad_gpio_in   = '0;
        repeat (4) @(negedge load_data);                  // Four reset cycles
        int_reset = 1'b0;
        check_bit("busy", busy, 1'b0);
        check_bit("done", done, 1'b0);
        fd = $fopen("gpio_testdata.txt", "r");
        if (fd == 0) begin
            $display("Could not open the test data file gpio_testdata.txt");
            abort_run();
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line.getc(0) == "/") begin
                continue;                                 // Comment or blank
            end
            pad_val  = '0;
            word_val = '0;
            void'($sscanf(line, "%c %h %h", cmd, pad_val, word_val));
            word     = gpio_pkg::pad_cfg_t'(word_val[gpio_pkg::PAD_CTRL_BITS-1:0]);
            case (cmd)
                "W": write_word(pad_val[ADDR_W-1:0], word);
                "S": run_transfer(1'b0, '0, '0);
                "B": run_transfer(1'b1, pad_val[ADDR_W-1:0], word);
                "R": check_readback(pad_val[ADDR_W-1:0], word);
                "P": check_pad(int'(pad_val[ADDR_W-1:0]), word);
                default: begin
                    $display("Unknown command in test data line %s", line);
                    abort_run();
                end
            endcase
        end
        $fclose(fd);
        $display("Testbench passed");
        $finish;
    end

endmodule

/* gpio_testdata.txt */
// Command letter then pad then 13 bit word in hex
// W write  S start  B start and write while busy  R readback  P pins  (reset word 0403)
P 0 0403
P 1 0403
P 2 0403
P 3 0403
W 0 1a55
W 1 0b2a
W 2 05c5
W 3 1f3e
S
R 0 0000
R 1 0000
R 2 0000
R 3 0000
P 0 1a55
P 1 0b2a
P 2 05c5
P 3 1f3e
W 0 0c3c
W 1 1e01
W 2 02d0
W 3 1557
S
R 0 1a55
R 1 0b2a
R 2 05c5
R 3 1f3e
P 0 0c3c
P 1 1e01
P 2 02d0
P 3 1557
B 2 0aaa
R 2 02d0
P 2 02d0
S
R 2 02d0

/* sim.f */
gpio_pkg.sv
gpio_control_block.sv
serial_cfg_master.sv
gpio_padframe_top.sv
gpio_padframe_asserts.sv
tb_gpio_padframe.sv

/* Makefile */
TOP := tb_gpio_padframe

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module $(TOP) -f sim.f

run: compile
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	grep -q "Testbench passed" sim.log

clean:
	rm -rf obj_dir sim.log
